//--- adder_tree.sv
`include "mv_params.svh"

module adder_tree (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  mv_pkg::result_t [`MV_LANES-1:0]    products,
    output mv_pkg::result_t                     sum,
    output logic                                sum_valid
);
    import mv_pkg::*;

    localparam int HALF    = `MV_LANES / 2;
    localparam int QUARTER = `MV_LANES / 4;

    // partial sums after the first two levels
    result_t [HALF-1:0]    stage1;
    result_t [QUARTER-1:0] stage2;
    // valid travels with the data, one bit per stage
    logic [`MV_TREE_STAGES-1:0] valid_pipe;

    // datapath registers, no reset needed
    // every add wraps at the result width
    always_ff @(posedge clk) begin
        // 8 to 4
        for (int i = 0; i < HALF; i++) begin
            stage1[i] <= products[2*i] + products[2*i+1];
        end
        // 4 to 2
        for (int i = 0; i < QUARTER; i++) begin
            stage2[i] <= stage1[2*i] + stage1[2*i+1];
        end
        // 2 to 1
        sum <= stage2[0] + stage2[1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`MV_TREE_STAGES-2:0], in_valid};
        end
    end

    // sum and sum_valid leave on the same cycle
    assign sum_valid = valid_pipe[`MV_TREE_STAGES-1];

endmodule

//--- lane_multiplier.sv
`include "mv_params.svh"

module lane_multiplier (
    input  logic            clk,
    input  logic            reset,
    input  logic            matrix_we,
    input  logic            vector_we,
    input  mv_pkg::row_t    wr_row,
    input  mv_pkg::row_t    rd_row,
    input  mv_pkg::word_t   wr_data,
    output mv_pkg::result_t product
);
    import mv_pkg::*;

    // one column of W, indexed by row
    word_t col_mem [`MV_LANES];
    // registered read of the column memory
    word_t rd_word;
    // this lane's element of x
    word_t vec_word;

    always_ff @(posedge clk) begin
        if (matrix_we) begin
            col_mem[wr_row] <= wr_data;
        end
        rd_word <= col_mem[rd_row];
    end

    // kept across vector-only loads until overwritten
    always_ff @(posedge clk) begin
        if (vector_we) begin
            vec_word <= wr_data;
        end
    end

    // signed multiply sized to the result width
    // 14 x 14 bits always fits in 28
    always_ff @(posedge clk) begin
        product <= rd_word * vec_word;
    end

    // the sequencer selects matrix or vector per word, never both
    a_one_target: assert property (@(posedge clk) disable iff (reset)
        !(matrix_we && vector_we));

endmodule

//--- list.f
+incdir+.
mv_pkg.sv
load_sequencer.sv
lane_multiplier.sv
adder_tree.sv
result_fifo.sv
mat_vec_top.sv
tb_mat_vec.sv

//--- load_sequencer.sv
`include "mv_params.svh"

module load_sequencer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  input_valid,
    input  logic                                  new_matrix,
    input  mv_pkg::word_t                         input_data,
    input  logic [$clog2(`MV_FIFO_DEPTH + 1)-1:0] free_count,
    output logic                                  input_ready,
    output mv_pkg::bank_write_t                   bank_wr,
    output mv_pkg::row_t                          rd_row,
    output logic                                  issue
);
    import mv_pkg::*;

    localparam int LANE_W     = $clog2(`MV_LANES);
    // drain ends once the last row has passed read, product and tree
    localparam int DRAIN_LAST = `MV_TREE_STAGES + 1;
    localparam int DRAIN_W    = $clog2(DRAIN_LAST + 1);

    typedef enum logic [1:0] {
        PH_LOAD,
        PH_COMPUTE,
        PH_DRAIN
    } phase_t;

    phase_t            phase;
    logic [LANE_W-1:0] lane_cnt;
    row_t              wr_row;
    row_t              row_cnt;
    logic [DRAIN_W-1:0] drain_cnt;
    // set once the first word of a load is taken
    logic              started;
    // still in the matrix part of the load
    logic              mat_flag;
    logic              accept;
    logic              is_matrix;
    logic              lane_wrap;
    lane_mask_t        lane_sel;

    // only the load phase takes words
    assign input_ready = phase == PH_LOAD;
    assign accept      = input_valid && input_ready;

    // new_matrix counts on the first word only
    assign is_matrix = started ? mat_flag : new_matrix;
    assign lane_wrap = lane_cnt == LANE_W'(`MV_LANES - 1);
    assign lane_sel  = lane_mask_t'(1) << lane_cnt;

    // one-hot bank select and the same word for every lane
    always_comb begin
        bank_wr.matrix_we = (accept && is_matrix) ? lane_sel : '0;
        bank_wr.vector_we = (accept && !is_matrix) ? lane_sel : '0;
        bank_wr.row       = wr_row;
        bank_wr.data      = input_data;
    end

    // row 0 waits for room for a full result set
    // later rows follow back to back
    assign issue  = (phase == PH_COMPUTE) && (row_cnt != '0 || free_count >= `MV_LANES);
    assign rd_row = row_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PH_LOAD;
            lane_cnt  <= '0;
            wr_row    <= '0;
            row_cnt   <= '0;
            drain_cnt <= '0;
            started   <= 1'b0;
            mat_flag  <= 1'b0;
        end else begin
            case (phase)
                PH_LOAD: begin
                    if (accept) begin
                        started  <= 1'b1;
                        lane_cnt <= lane_wrap ? '0 : lane_cnt + 1'b1;
                        mat_flag <= is_matrix;
                        if (lane_wrap && is_matrix) begin
                            // step to the next row
                            wr_row   <= wr_row + 1'b1;
                            mat_flag <= wr_row != row_t'(`MV_LANES - 1);
                        end else if (lane_wrap) begin
                            // last vector word
                            phase   <= PH_COMPUTE;
                            started <= 1'b0;
                        end
                    end
                end
                PH_COMPUTE: begin
                    if (issue) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == row_t'(`MV_LANES - 1)) begin
                            phase <= PH_DRAIN;
                        end
                    end
                end
                PH_DRAIN: begin
                    // wait for the last row to reach the FIFO
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_W'(DRAIN_LAST)) begin
                        drain_cnt <= '0;
                        phase     <= PH_LOAD;
                    end
                end
                default: phase <= PH_LOAD;
            endcase
        end
    end

    // rows leave back to back and the burst stops after the last row
    a_row_burst: assert property (@(posedge clk) disable iff (reset)
        issue |=> issue == (rd_row != '0));

endmodule

//--- mat_vec_cases.txt
# new_matrix flag, then with flag 1 the 64 words of W row by row, then x[0] to x[7]
# signed decimal words in -8192..8191, line breaks and blank lines are free
1
     1      2      3      4      5      6      7      8
    -1     -2     -3     -4     -5     -6     -7     -8
   100   -200    300   -400    500   -600    700   -800
     0      0      0      0      0      0      0      0
  8191      0      0      0      0      0      0  -8192
    17    -33    250   4095  -4096     12     -7   1000
 -1234   2345  -3456   4567  -5678   6789  -7890   8000
     1      1      1      1      1      1      1      1
     3     -5      7    -11     13    -17     19    -23

0    1      0      0      0      0      0      0      0
0 8191   8191   8191   8191   8191   8191   8191   8191
0 -8192 -8192  -8192  -8192  -8192  -8192  -8192  -8192
0 -4000  3000  -2000   1000      0  -1000   2000  -3000

1
  8191   8191   8191   8191   8191   8191   8191   8191
 -8192  -8192  -8192  -8192  -8192  -8192  -8192  -8192
  8191  -8192   8191  -8192   8191  -8192   8191  -8192
 -8192   8191  -8192   8191  -8192   8191  -8192   8191
  8191   8191   8191   8191  -8192  -8192  -8192  -8192
    -1     -1     -1     -1     -1     -1     -1     -1
     0      0      0      0      0      0      0      0
  4096   4096   4096   4096   4096   4096   4096   4096
 -8192  -8192  -8192  -8192  -8192  -8192  -8192  -8192
0 8191   8191   8191   8191   8191   8191   8191   8191
0 -8192  8191  -8192   8191  -8192   8191  -8192   8191

//--- mat_vec_top.sv
`include "mv_params.svh"

module mat_vec_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            input_valid,
    input  logic            new_matrix,
    input  logic            output_ready,
    input  mv_pkg::word_t   input_data,
    output logic            input_ready,
    output logic            output_valid,
    output mv_pkg::result_t output_data
);
    import mv_pkg::*;

    localparam int CNT_W = $clog2(`MV_FIFO_DEPTH + 1);

    bank_write_t                 bank_wr;
    row_t                        rd_row;
    logic                        issue;
    // issue delayed by memory read and product register
    logic [1:0]                  issue_dly;
    result_t [`MV_LANES-1:0]     products;
    result_t                     sum;
    logic                        sum_valid;
    logic [CNT_W-1:0]            free_count;

    load_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .input_valid (input_valid),
        .new_matrix  (new_matrix),
        .input_data  (input_data),
        .free_count  (free_count),
        .input_ready (input_ready),
        .bank_wr     (bank_wr),
        .rd_row      (rd_row),
        .issue       (issue)
    );

    // lane c holds column c of W and x[c]
    for (genvar c = 0; c < `MV_LANES; c++) begin : g_lane
        lane_multiplier u_lane (
            .clk       (clk),
            .reset     (reset),
            .matrix_we (bank_wr.matrix_we[c]),
            .vector_we (bank_wr.vector_we[c]),
            .wr_row    (bank_wr.row),
            .rd_row    (rd_row),
            .wr_data   (bank_wr.data),
            .product   (products[c])
        );
    end

    // line up the row strobe with the lane products
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_dly <= '0;
        end else begin
            issue_dly <= {issue_dly[0], issue};
        end
    end

    adder_tree u_tree (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (issue_dly[1]),
        .products  (products),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    // row sums queue here until the consumer takes them
    result_fifo u_fifo (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (sum_valid),
        .output_ready (output_ready),
        .wr_data      (sum),
        .output_valid (output_valid),
        .output_data  (output_data),
        .free_count   (free_count)
    );

endmodule

//--- mv_params.svh
`ifndef MV_PARAMS_SVH
`define MV_PARAMS_SVH

// lane count, also the matrix dimension
`define MV_LANES 8

// signed input word width
`define MV_WORD_W 14

// product and row sum width
// everything past this many bits wraps
`define MV_RESULT_W 28

// row address width into each column memory
`define MV_ROW_W 3

// result buffer entries, power of two
`define MV_FIFO_DEPTH 16

// register stages in the adder tree
`define MV_TREE_STAGES 3

`endif

//--- mv_pkg.sv
`include "mv_params.svh"

package mv_pkg;

    // one input element
    typedef logic signed [`MV_WORD_W-1:0] word_t;

    // lane product or row sum
    typedef logic signed [`MV_RESULT_W-1:0] result_t;

    // row index into a column memory
    typedef logic [`MV_ROW_W-1:0] row_t;

    // one bit per lane, at most one set
    typedef logic [`MV_LANES-1:0] lane_mask_t;

    // everything a lane needs to capture one input word
    typedef struct packed {
        // column memory write select
        lane_mask_t matrix_we;
        // vector register write select
        lane_mask_t vector_we;
        // matrix row being filled
        row_t       row;
        // the word itself
        word_t      data;
    } bank_write_t;

endpackage

//--- result_fifo.sv
`include "mv_params.svh"

module result_fifo (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wr_en,
    input  logic                                  output_ready,
    input  mv_pkg::result_t                       wr_data,
    output logic                                  output_valid,
    output mv_pkg::result_t                       output_data,
    output logic [$clog2(`MV_FIFO_DEPTH + 1)-1:0] free_count
);
    import mv_pkg::*;

    localparam int PTR_W = $clog2(`MV_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`MV_FIFO_DEPTH + 1);

    result_t          mem [`MV_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // entries currently held
    logic [CNT_W-1:0] count;
    logic             rd_en;

    // first word fall-through, head is always visible
    assign output_valid = count != '0;
    assign output_data  = mem[rd_ptr];
    assign rd_en        = output_valid && output_ready;
    assign free_count   = CNT_W'(`MV_FIFO_DEPTH) - count;

    // storage only, no reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // upstream checks free_count before issuing, so a full buffer never sees a write
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> count != CNT_W'(`MV_FIFO_DEPTH));

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_mat_vec -o sim_mat_vec
./obj_dir/sim_mat_vec | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"

//--- tb_mat_vec.sv
`include "mv_params.svh"

module tb_mat_vec;
    timeunit 1ns;
    timeprecision 1ps;

    import mv_pkg::*;

    localparam int N          = `MV_LANES;
    // eight row issues plus five cycles from issue to the FIFO write
    localparam int STALL_MIN  = `MV_LANES + 5;
    localparam int WAIT_LIMIT = 2000;

    logic    clk;
    logic    reset;
    logic    input_valid;
    logic    new_matrix;
    logic    output_ready;
    word_t   input_data;
    logic    input_ready;
    logic    output_valid;
    result_t output_data;

    // reference copy of W and x
    int w_model [N][N];
    int x_model [N];

    // expected sums in arrival order
    // tag is load * N + row
    result_t exp_q [$];
    int      tag_q [$];

    int value_errors;
    int other_errors;
    int timeouts;
    int results_seen;
    bit timed_out;

    mat_vec_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .new_matrix   (new_matrix),
        .output_ready (output_ready),
        .input_data   (input_data),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_data  (output_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // y[r] from the model wrapped to the result width
    function automatic result_t model_row(input int r);
        longint acc;
        acc = 0;
        for (int c = 0; c < N; c++) begin
            acc += longint'(w_model[r][c]) * longint'(x_model[c]);
        end
        return result_t'(acc);
    endfunction

    // compare one transferred result against the head of the queue
    task automatic check_result(input result_t got);
        result_t want;
        int      tag;
        if (exp_q.size() == 0) begin
            $display("Fail at %0t: result %0d arrived with none expected", $time, got);
            value_errors++;
        end else begin
            want = exp_q.pop_front();
            tag  = tag_q.pop_front();
            results_seen++;
            if (got !== want) begin
                $display("Fail at %0t: load %0d row %0d gave %0d, expected %0d",
                         $time, tag / N, tag % N, got, want);
                value_errors++;
            end
        end
    endtask

    // one word on the input handshake
    // called and returning at a falling edge
    task automatic send_word(input int value, input bit first, input bit flag);
        int gap;
        int waited;
        // random idle cycles before the word
        gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
        for (int i = 0; i < gap; i++) begin
            input_valid = 1'b0;
            @(negedge clk);
        end
        input_valid = 1'b1;
        input_data  = word_t'(value);
        // flag counts on the first word only
        // other words carry random noise
        new_matrix  = first ? flag : ($urandom_range(0, 1) == 1);
        // ready never drops inside a load
        if (input_ready !== 1'b1) begin
            $display("Fail at %0t: input_ready low while a load is in progress", $time);
            value_errors++;
        end
        waited = 0;
        while (!input_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!input_ready) begin
            $display("timeout: input_ready stayed low for %0d cycles in a load", waited);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            // taken at the rising edge in between
            @(negedge clk);
        end
        input_valid = 1'b0;
    endtask

    // ready stays low in the compute phase and junk words are ignored
    task automatic check_stall(input int load_idx);
        int low_cycles;
        low_cycles = 0;
        if (input_ready !== 1'b0) begin
            $display("Fail at %0t: load %0d input_ready high after last vector word",
                     $time, load_idx);
            value_errors++;
        end
        while (input_ready !== 1'b1 && low_cycles < WAIT_LIMIT) begin
            input_valid = 1'b1;
            input_data  = word_t'($urandom);
            new_matrix  = ($urandom_range(0, 1) == 1);
            @(negedge clk);
            low_cycles++;
        end
        // drop valid before the first edge with ready high
        input_valid = 1'b0;
        if (input_ready !== 1'b1) begin
            $display("timeout: input_ready never rose after load %0d", load_idx);
            timeouts++;
            timed_out = 1'b1;
        end else if (low_cycles < STALL_MIN) begin
            $display("Fail at %0t: load %0d input_ready low %0d cycles, expected at least %0d",
                     $time, load_idx, low_cycles, STALL_MIN);
            value_errors++;
        end
    endtask

    // read one load from the file, queue its results, then drive it
    task automatic run_load(input int fd, input int load_idx, input bit flag);
        int value;
        int code;
        if (flag) begin
            for (int k = 0; k < N * N; k++) begin
                code = $fscanf(fd, "%d", value);
                if (code != 1) begin
                    $display("case file ends inside the matrix of load %0d", load_idx);
                    other_errors++;
                    return;
                end
                w_model[k / N][k % N] = value;
            end
        end
        for (int c = 0; c < N; c++) begin
            code = $fscanf(fd, "%d", value);
            if (code != 1) begin
                $display("case file ends inside the vector of load %0d", load_idx);
                other_errors++;
                return;
            end
            x_model[c] = value;
        end
        for (int r = 0; r < N; r++) begin
            exp_q.push_back(model_row(r));
            tag_q.push_back(load_idx * N + r);
        end
        // matrix words row-major and then x
        if (flag) begin
            for (int k = 0; k < N * N && !timed_out; k++) begin
                send_word(w_model[k / N][k % N], k == 0, flag);
            end
        end
        for (int c = 0; c < N && !timed_out; c++) begin
            send_word(x_model[c], !flag && c == 0, flag);
        end
        if (!timed_out) begin
            check_stall(load_idx);
        end
    endtask

    // random back-pressure on the output with long low stretches
    initial begin
        int  hold;
        bit  level;
        hold         = 0;
        level        = 1'b0;
        output_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (hold == 0) begin
                level = ($urandom_range(0, 2) != 0);
                hold  = level ? $urandom_range(1, 6) : $urandom_range(1, 40);
            end
            hold--;
            output_ready = level;
            // outputs are stable here and transfer at the next rise
            if (!reset && output_valid && output_ready) begin
                check_result(output_data);
            end
        end
    end

    initial begin
        int               fd;
        int               code;
        int               flag;
        int               load_idx;
        int               waited;
        logic [8*256-1:0] skip_line;
        void'($urandom(32'hb0e6));
        reset           = 1'b1;
        input_valid     = 1'b0;
        new_matrix      = 1'b0;
        input_data      = '0;
        value_errors    = 0;
        other_errors    = 0;
        timeouts        = 0;
        results_seen    = 0;
        timed_out       = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (output_valid !== 1'b0 || input_ready !== 1'b1) begin
            $display("Fail at %0t: after reset output_valid %b input_ready %b",
                     $time, output_valid, input_ready);
            value_errors++;
        end
        fd = $fopen("mat_vec_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open mat_vec_cases.txt");
            other_errors++;
        end
        load_idx = 0;
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            code = $fscanf(fd, "%d", flag);
            if (code == 1) begin
                if (flag != 0 && flag != 1) begin
                    $display("load %0d has flag %0d, not 0 or 1", load_idx, flag);
                    other_errors++;
                end
                run_load(fd, load_idx, flag != 0);
                load_idx++;
            end else if (code == 0) begin
                // comment line
                code = $fgets(skip_line, fd);
            end else begin
                break;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (load_idx == 0) begin
            $display("no loads were read from the case file");
            other_errors++;
        end
        // let the FIFO drain
        waited = 0;
        while (!timed_out && exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never came out", exp_q.size());
            timeouts++;
        end else begin
            repeat (2) @(negedge clk);
            if (output_valid !== 1'b0) begin
                $display("Fail at %0t: extra result %0d left in the FIFO", $time, output_data);
                value_errors++;
            end
        end
        $display("loads %0d, results %0d, value errors %0d, other errors %0d, timeouts %0d",
                 load_idx, results_seen, value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
